// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_audio_top
FILELIST  = verilog.f
BUILD     = obj_dir
BIN       = $(BUILD)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== design/audio_pkg.sv ====
/*
 * Shared types and constants for the stereo 2x interpolator.
 * Samples are 18-bit signed and the accumulator is 48-bit signed.
 * Gain is unsigned Q2.14, so 16384 is unity and the top is just under 4.0.
 * COEFS is a fixed half-band table and cannot be reloaded.
 */
package audio_pkg;

    typedef logic signed [17:0] sample_t;
    typedef logic signed [47:0] acc_t;
    typedef logic [15:0]        gain_t;

    typedef enum logic [1:0] {
        MAC_NOP = 2'd0,
        MAC_MUL = 2'd1,
        MAC_MAC = 2'd2
    } mac_op_t;

    // Filter
    localparam int NUM_TAPS  = 34;
    localparam int TAP_W     = 6;
    localparam int MID_TAP   = 17;
    localparam int FIR_SHIFT = 16;

    localparam sample_t COEFS [NUM_TAPS] = '{
        1, -5, 13, -30, 56, -101, 167, -265, 401, -591, 850, -1211,
        1720, -2492, 3809, -6731, 20785, 20785, -6731, 3809, -2492, 1720,
        -1211, 850, -591, 401, -265, 167, -101, 56, -30, 13, -5, 1
    };

    // Gain and register map
    localparam int         GAIN_SHIFT    = 14;
    localparam gain_t      GAIN_RESET    = 16'd16384;
    localparam logic [3:0] REG_GAIN_ADDR = 4'h0;

    // Fixed depth of the shared MAC pipeline
    localparam int MAC_LATENCY = 2;

endpackage

// ==== design/audio_top.sv ====
/*
 * Stereo 2x interpolator with programmable gain and an APB register port.
 * sample_in_valid is a strobe taken only while busy is low.
 * Two sample_out_valid pulses follow every accepted input.
 */
`timescale 1ns/1ns

module audio_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               sample_in_valid,
    input  audio_pkg::sample_t sample_in_l,
    input  audio_pkg::sample_t sample_in_r,
    output logic               busy,
    output logic               sample_out_valid,
    output audio_pkg::sample_t sample_out_l,
    output audio_pkg::sample_t sample_out_r,
    input  logic [3:0]         paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr
);
    import audio_pkg::*;

    mac_if gain_mac ();
    mac_if fir_mac ();

    gain_t   gain;
    logic    mid_valid;
    logic    mid_ready;
    sample_t mid_l;
    sample_t mid_r;
    mac_op_t op;
    sample_t a_l;
    sample_t a_r;
    sample_t b_l;
    sample_t b_r;
    acc_t    p_l;
    acc_t    p_r;
    logic    p_valid;

    interpolator_2x interp0 (
        .clk             (clk),
        .reset           (reset),
        .sample_in_valid (sample_in_valid),
        .sample_in_l     (sample_in_l),
        .sample_in_r     (sample_in_r),
        .busy            (busy),
        .mid_valid       (mid_valid),
        .mid_l           (mid_l),
        .mid_r           (mid_r),
        .mid_ready       (mid_ready),
        .mac             (fir_mac.requester)
    );

    gain_stage gain0 (
        .clk              (clk),
        .reset            (reset),
        .gain             (gain),
        .mid_valid        (mid_valid),
        .mid_l            (mid_l),
        .mid_r            (mid_r),
        .mid_ready        (mid_ready),
        .sample_out_valid (sample_out_valid),
        .sample_out_l     (sample_out_l),
        .sample_out_r     (sample_out_r),
        .mac              (gain_mac.requester)
    );

    gain_regs regs0 (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .gain    (gain)
    );

    // Gain stage on the high-priority side so outputs always drain
    mac_arbiter arb0 (
        .clk     (clk),
        .reset   (reset),
        .req_hi  (gain_mac.arbiter),
        .req_lo  (fir_mac.arbiter),
        .op      (op),
        .a_l     (a_l),
        .a_r     (a_r),
        .b_l     (b_l),
        .b_r     (b_r),
        .p_l     (p_l),
        .p_r     (p_r),
        .p_valid (p_valid)
    );

    mac_unit mac0 (
        .clk     (clk),
        .reset   (reset),
        .op      (op),
        .a_l     (a_l),
        .a_r     (a_r),
        .b_l     (b_l),
        .b_r     (b_r),
        .p_l     (p_l),
        .p_r     (p_r),
        .p_valid (p_valid)
    );

endmodule

// ==== design/gain_regs.sv ====
/*
 * APB slave for the gain register, no wait states.
 * Only REG_GAIN_ADDR is mapped; other addresses answer with pslverr.
 * Writes take the low 16 bits of pwdata; reads return the gain zero-extended.
 */
`timescale 1ns/1ns

module gain_regs (
    input  logic             clk,
    input  logic             reset,
    input  logic [3:0]       paddr,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output audio_pkg::gain_t gain
);
    import audio_pkg::*;

    logic hit;
    logic access;

    assign hit     = (paddr == REG_GAIN_ADDR);
    assign access  = psel && penable;
    assign pready  = 1'b1;
    assign pslverr = access && !hit;
    assign prdata  = (psel && !pwrite && hit) ? 32'(gain) : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            gain <= GAIN_RESET;
        end else if (access && pwrite && hit) begin
            gain <= pwdata[$bits(gain_t)-1:0];
        end
    end

endmodule

// ==== design/gain_stage.sv ====
/*
 * Scales each interpolated stereo sample by a Q2.14 gain and saturates to 18 bits.
 * The gain is taken once per sample, when that sample is accepted.
 * Output follows the MAC grant by MAC_LATENCY+2 cycles.
 */
`timescale 1ns/1ns

module gain_stage (
    input  logic               clk,
    input  logic               reset,
    input  audio_pkg::gain_t   gain,
    input  logic               mid_valid,
    input  audio_pkg::sample_t mid_l,
    input  audio_pkg::sample_t mid_r,
    output logic               mid_ready,
    output logic               sample_out_valid,
    output audio_pkg::sample_t sample_out_l,
    output audio_pkg::sample_t sample_out_r,
    mac_if.requester           mac
);
    import audio_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_SAT
    } state_t;

    state_t  state;
    sample_t s_l;
    sample_t s_r;
    gain_t   g_q;
    acc_t    sh_l;
    acc_t    sh_r;

    function automatic sample_t saturate(input acc_t v);
        if (v > acc_t'(131071)) begin
            return sample_t'(131071);
        end
        if (v < acc_t'(-131072)) begin
            return sample_t'(-131072);
        end
        return sample_t'(v);
    endfunction

    assign mid_ready = (state == ST_IDLE);

    // One multiply per sample, gain zero-extended into the B port
    assign mac.req  = (state == ST_REQ);
    assign mac.last = 1'b1;
    assign mac.op   = MAC_MUL;
    assign mac.a_l  = s_l;
    assign mac.a_r  = s_r;
    assign mac.b_l  = sample_t'(g_q);
    assign mac.b_r  = sample_t'(g_q);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state            <= ST_IDLE;
            sample_out_valid <= 1'b0;
        end else begin
            sample_out_valid <= (state == ST_SAT);
            case (state)
                ST_IDLE: if (mid_valid) state <= ST_REQ;
                ST_REQ:  if (mac.gnt) state <= ST_WAIT;
                ST_WAIT: if (mac.p_valid) state <= ST_SAT;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mid_valid && mid_ready) begin
            s_l <= mid_l;
            s_r <= mid_r;
            g_q <= gain;
        end
        if (mac.p_valid) begin
            sh_l <= mac.p_l >>> GAIN_SHIFT;
            sh_r <= mac.p_r >>> GAIN_SHIFT;
        end
        if (state == ST_SAT) begin
            sample_out_l <= saturate(sh_l);
            sample_out_r <= saturate(sh_r);
        end
    end

    // Arbiter must route back only results this stage asked for
    a_result_owned: assert property (@(posedge clk) disable iff (reset)
        mac.p_valid |-> (state == ST_WAIT));

endmodule

// ==== design/interpolator_2x.sv ====
/*
 * 34-tap 2x interpolator run by a small microsequencer.
 * Each accepted input gives the FIR phase, then x[n-17] >>> 1.
 * An input offered while busy is dropped; there is no input buffering.
 * Takes at least NUM_TAPS+MAC_LATENCY+4 cycles per input.
 */
`timescale 1ns/1ns

module interpolator_2x (
    input  logic               clk,
    input  logic               reset,
    input  logic               sample_in_valid,
    input  audio_pkg::sample_t sample_in_l,
    input  audio_pkg::sample_t sample_in_r,
    output logic               busy,
    output logic               mid_valid,
    output audio_pkg::sample_t mid_l,
    output audio_pkg::sample_t mid_r,
    input  logic               mid_ready,
    mac_if.requester           mac
);
    import audio_pkg::*;

    typedef enum logic [2:0] {
        PC_WAIT,
        PC_PUSH,
        PC_MAC,
        PC_DRAIN,
        PC_FIR,
        PC_HALF
    } pc_t;

    pc_t              pc;
    logic [TAP_W-1:0] head;
    logic [TAP_W-1:0] head_next;
    logic [TAP_W-1:0] rd_ptr;
    logic [TAP_W-1:0] mid_ptr;
    logic [TAP_W-1:0] tap;
    logic             tap_last;
    logic             issue;
    sample_t          in_l;
    sample_t          in_r;
    sample_t          dl_l [NUM_TAPS];
    sample_t          dl_r [NUM_TAPS];
    acc_t             acc_l;
    acc_t             acc_r;

    assign busy     = (pc != PC_WAIT);
    assign issue    = mac.req && mac.gnt;
    assign tap_last = (tap == TAP_W'(NUM_TAPS - 1));

    // Head moves backwards so x[n-k] sits at head+k
    assign head_next = (head == '0) ? TAP_W'(NUM_TAPS - 1) : head - 1'b1;
    assign mid_ptr   = (head >= TAP_W'(NUM_TAPS - MID_TAP)) ?
                       head - TAP_W'(NUM_TAPS - MID_TAP) : head + TAP_W'(MID_TAP);

    always_ff @(posedge clk) begin
        if (pc == PC_WAIT && sample_in_valid) begin
            in_l <= sample_in_l;
            in_r <= sample_in_r;
        end
    end

    // ----------------------------------------------------------
    // Sequencer
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc     <= PC_WAIT;
            head   <= '0;
            rd_ptr <= '0;
            tap    <= '0;
        end else begin
            case (pc)
                PC_WAIT: begin
                    if (sample_in_valid) begin
                        pc <= PC_PUSH;
                    end
                end
                PC_PUSH: begin
                    head   <= head_next;
                    rd_ptr <= head_next;
                    tap    <= '0;
                    pc     <= PC_MAC;
                end
                PC_MAC: begin
                    if (issue) begin
                        rd_ptr <= (rd_ptr == TAP_W'(NUM_TAPS - 1)) ? '0 : rd_ptr + 1'b1;
                        if (tap_last) begin
                            tap <= '0;
                            pc  <= PC_DRAIN;
                        end else begin
                            tap <= tap + 1'b1;
                        end
                    end
                end
                PC_DRAIN: begin
                    // Let the last product leave the pipeline
                    if (tap == TAP_W'(MAC_LATENCY - 1)) begin
                        pc <= PC_FIR;
                    end else begin
                        tap <= tap + 1'b1;
                    end
                end
                PC_FIR: begin
                    if (mid_ready) begin
                        pc <= PC_HALF;
                    end
                end
                PC_HALF: begin
                    if (mid_ready) begin
                        pc <= PC_WAIT;
                    end
                end
                default: pc <= PC_WAIT;
            endcase
        end
    end

    // Delay line, cleared so the first outputs see silence
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                dl_l[k] <= '0;
                dl_r[k] <= '0;
            end
        end else if (pc == PC_PUSH) begin
            dl_l[head_next] <= in_l;
            dl_r[head_next] <= in_r;
        end
    end

    // Last result of the burst is the one left here
    always_ff @(posedge clk) begin
        if (mac.p_valid) begin
            acc_l <= mac.p_l;
            acc_r <= mac.p_r;
        end
    end

    // ----------------------------------------------------------
    // MAC requests and outputs
    // ----------------------------------------------------------
    assign mac.req  = (pc == PC_MAC);
    assign mac.last = tap_last;
    assign mac.op   = (tap == '0) ? MAC_MUL : MAC_MAC;
    assign mac.a_l  = COEFS[tap];
    assign mac.a_r  = COEFS[tap];
    assign mac.b_l  = dl_l[rd_ptr];
    assign mac.b_r  = dl_r[rd_ptr];

    assign mid_valid = ((pc == PC_FIR) || (pc == PC_HALF)) && mid_ready;

    always_comb begin
        if (pc == PC_FIR) begin
            mid_l = acc_l[FIR_SHIFT +: $bits(sample_t)];
            mid_r = acc_r[FIR_SHIFT +: $bits(sample_t)];
        end else begin
            mid_l = dl_l[mid_ptr] >>> 1;
            mid_r = dl_r[mid_ptr] >>> 1;
        end
    end

    // Grant lock keeps the slice for the whole burst once tap 0 has issued
    a_burst_granted: assert property (@(posedge clk) disable iff (reset)
        (mac.req && tap != '0) |-> mac.gnt);

endmodule

// ==== design/mac_arbiter.sv ====
/*
 * Fixed-priority arbiter in front of the single MAC slice.
 * req_hi always wins a free slice; a granted burst keeps the slice until last.
 * Results go back only to the requester that issued the operation.
 */
`timescale 1ns/1ns

module mac_arbiter (
    input  logic               clk,
    input  logic               reset,
    mac_if.arbiter             req_hi,
    mac_if.arbiter             req_lo,
    output audio_pkg::mac_op_t op,
    output audio_pkg::sample_t a_l,
    output audio_pkg::sample_t a_r,
    output audio_pkg::sample_t b_l,
    output audio_pkg::sample_t b_r,
    input  audio_pkg::acc_t    p_l,
    input  audio_pkg::acc_t    p_r,
    input  logic               p_valid
);
    import audio_pkg::*;

    logic                   lock_q;
    logic                   owner_hi_q;
    logic                   gnt_hi;
    logic                   gnt_lo;
    logic                   issue_hi;
    logic                   issue_lo;
    logic [MAC_LATENCY-1:0] src_hi;

    // ----------------------------------------------------------
    // Grant
    // ----------------------------------------------------------
    always_comb begin
        gnt_hi = 1'b0;
        gnt_lo = 1'b0;
        if (lock_q) begin
            gnt_hi = owner_hi_q;
            gnt_lo = !owner_hi_q;
        end else if (req_hi.req) begin
            gnt_hi = 1'b1;
        end else if (req_lo.req) begin
            gnt_lo = 1'b1;
        end
    end

    assign issue_hi   = gnt_hi && req_hi.req;
    assign issue_lo   = gnt_lo && req_lo.req;
    assign req_hi.gnt = gnt_hi;
    assign req_lo.gnt = gnt_lo;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lock_q     <= 1'b0;
            owner_hi_q <= 1'b0;
            src_hi     <= '0;
        end else begin
            // Tracks who owns each result still in the pipeline
            src_hi <= (src_hi << 1) | issue_hi;
            if (issue_hi) begin
                lock_q     <= !req_hi.last;
                owner_hi_q <= 1'b1;
            end else if (issue_lo) begin
                lock_q     <= !req_lo.last;
                owner_hi_q <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------
    // Operand mux and result fan-out
    // ----------------------------------------------------------
    assign op  = issue_hi ? req_hi.op : (issue_lo ? req_lo.op : MAC_NOP);
    assign a_l = gnt_hi ? req_hi.a_l : req_lo.a_l;
    assign a_r = gnt_hi ? req_hi.a_r : req_lo.a_r;
    assign b_l = gnt_hi ? req_hi.b_l : req_lo.b_l;
    assign b_r = gnt_hi ? req_hi.b_r : req_lo.b_r;

    assign req_hi.p_l     = p_l;
    assign req_hi.p_r     = p_r;
    assign req_lo.p_l     = p_l;
    assign req_lo.p_r     = p_r;
    assign req_hi.p_valid = p_valid && src_hi[MAC_LATENCY-1];
    assign req_lo.p_valid = p_valid && !src_hi[MAC_LATENCY-1];

    // Result routing relies on the slice answering exactly MAC_LATENCY after issue
    a_result_timing: assert property (@(posedge clk) disable iff (reset)
        p_valid == $past(issue_hi || issue_lo, MAC_LATENCY));

endmodule

// ==== design/mac_if.sv ====
/*
 * One requester's link to the shared MAC slice.
 * An operation issues in every cycle where req and gnt are both high.
 * last marks the final operation of a burst and releases the grant lock.
 */
`timescale 1ns/1ns

interface mac_if;
    import audio_pkg::*;

    logic    req;
    logic    last;
    mac_op_t op;
    sample_t a_l;
    sample_t a_r;
    sample_t b_l;
    sample_t b_r;
    logic    gnt;
    acc_t    p_l;
    acc_t    p_r;
    logic    p_valid;

    modport requester (
        output req, last, op, a_l, a_r, b_l, b_r,
        input  gnt, p_l, p_r, p_valid
    );

    modport arbiter (
        input  req, last, op, a_l, a_r, b_l, b_r,
        output gnt, p_l, p_r, p_valid
    );

endinterface

// ==== design/mac_unit.sv ====
/*
 * Two-lane multiply-accumulate slice, one lane per stereo channel.
 * The result of an operation appears MAC_LATENCY (2) cycles after it is issued.
 * The accumulator is shared, so a MAC_MAC burst must not be interleaved.
 */
`timescale 1ns/1ns

module mac_unit (
    input  logic               clk,
    input  logic               reset,
    input  audio_pkg::mac_op_t op,
    input  audio_pkg::sample_t a_l,
    input  audio_pkg::sample_t a_r,
    input  audio_pkg::sample_t b_l,
    input  audio_pkg::sample_t b_r,
    output audio_pkg::acc_t    p_l,
    output audio_pkg::acc_t    p_r,
    output logic               p_valid
);
    import audio_pkg::*;

    mac_op_t op_d;
    acc_t    prod_l;
    acc_t    prod_r;

    // Stage 1 registers the products
    always_ff @(posedge clk) begin
        prod_l <= a_l * b_l;
        prod_r <= a_r * b_r;
    end

    // Stage 2 loads or accumulates on the delayed op
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_d    <= MAC_NOP;
            p_valid <= 1'b0;
            p_l     <= '0;
            p_r     <= '0;
        end else begin
            op_d    <= op;
            p_valid <= (op_d != MAC_NOP);
            if (op_d == MAC_MUL) begin
                p_l <= prod_l;
                p_r <= prod_r;
            end else if (op_d == MAC_MAC) begin
                p_l <= p_l + prod_l;
                p_r <= p_r + prod_r;
            end
        end
    end

endmodule

// ==== dv/tb_audio_top.sv ====
/*
 * Testbench for audio_top. Rows of the stimulus table run back to back
 * and the delay-line model carries across rows, just as the DUT does.
 * Row 0 must be the left impulse at unity gain, because it is also
 * checked directly against COEFS. Stops at the first mismatch.
 */
`timescale 1ns/1ns

module tb_audio_top;
    import audio_pkg::*;

    localparam int CLK_HALF = 50;
    localparam int NUM_ROWS = 7;

    typedef enum logic [2:0] {
        IN_ZERO,
        IN_IMPULSE,
        IN_RAMP,
        IN_RAND,
        IN_POS_FS,
        IN_NEG_FS
    } in_kind_t;

    typedef struct packed {
        gain_t      gain;
        in_kind_t   kind_l;
        in_kind_t   kind_r;
        logic [7:0] count;
        logic       ghost;
    } row_t;

    // Gain, left input, right input, sample count, extra strobe while busy
    localparam row_t ROWS [NUM_ROWS] = '{
        '{16'd16384, IN_IMPULSE, IN_ZERO,    8'd40, 1'b0},
        '{16'd16384, IN_RAND,    IN_RAND,    8'd40, 1'b0},
        '{16'd16384, IN_RAMP,    IN_RAND,    8'd20, 1'b1},
        '{16'd8192,  IN_RAND,    IN_RAMP,    8'd24, 1'b0},
        '{16'd65372, IN_POS_FS,  IN_NEG_FS,  8'd40, 1'b0},
        '{16'd65372, IN_RAND,    IN_RAND,    8'd24, 1'b1},
        '{16'd16384, IN_ZERO,    IN_IMPULSE, 8'd40, 1'b1}
    };

    logic        clk;
    logic        reset;
    logic        sample_in_valid;
    sample_t     sample_in_l;
    sample_t     sample_in_r;
    logic        busy;
    logic        sample_out_valid;
    sample_t     sample_out_l;
    sample_t     sample_out_r;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [15:0] lfsr;
    sample_t     hist_l [NUM_TAPS];
    sample_t     hist_r [NUM_TAPS];
    sample_t     exp_l [2];
    sample_t     exp_r [2];
    int          cycles;
    int          limit;
    int          sat_hi;
    int          sat_lo;

    audio_top dut0 (
        .clk              (clk),
        .reset            (reset),
        .sample_in_valid  (sample_in_valid),
        .sample_in_l      (sample_in_l),
        .sample_in_r      (sample_in_r),
        .busy             (busy),
        .sample_out_valid (sample_out_valid),
        .sample_out_l     (sample_out_l),
        .sample_out_r     (sample_out_r),
        .paddr            (paddr),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            fail_stop($sformatf("Timeout after %0d cycles, DUT stopped answering", cycles));
        end
    end

    // ------------------------------------------------------------
    // Error handling and compare tasks
    // ------------------------------------------------------------
    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("Fail at %0t ns: %s got %0d expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("Fail at %0t ns: %s got 0x%08h expected 0x%08h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_stop($sformatf("Fail at %0t ns: %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus sources and reference model
    // ------------------------------------------------------------
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return b;
    endfunction

    function automatic sample_t rand_sample();
        sample_t v;
        for (int k = 0; k < $bits(sample_t); k++) begin
            v = {v[$bits(sample_t)-2:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic sample_t make_input(input in_kind_t kind, input int i);
        case (kind)
            IN_IMPULSE: return (i == 0) ? sample_t'(65536) : sample_t'(0);
            IN_RAMP:    return sample_t'(i * 2731 - 40000);
            IN_RAND:    return rand_sample();
            IN_POS_FS:  return sample_t'(131071);
            IN_NEG_FS:  return sample_t'(-131072);
            default:    return sample_t'(0);
        endcase
    endfunction

    function automatic sample_t model_fir(input logic right);
        longint      acc;
        logic [63:0] bits;
        acc = 0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            acc += longint'(COEFS[k]) * longint'(right ? hist_r[k] : hist_l[k]);
        end
        bits = acc;
        return sample_t'(bits[FIR_SHIFT +: $bits(sample_t)]);
    endfunction

    function automatic sample_t model_gain(input sample_t y, input gain_t g);
        longint p;
        p = longint'(y) * longint'(g);
        p = p >>> GAIN_SHIFT;
        if (p > 131071) begin
            return sample_t'(131071);
        end
        if (p < -131072) begin
            return sample_t'(-131072);
        end
        return sample_t'(p);
    endfunction

    // Newest sample at index 0
    task automatic model_push(input sample_t xl, input sample_t xr, input gain_t g);
        for (int k = NUM_TAPS - 1; k > 0; k--) begin
            hist_l[k] = hist_l[k-1];
            hist_r[k] = hist_r[k-1];
        end
        hist_l[0] = xl;
        hist_r[0] = xr;
        exp_l[0] = model_gain(model_fir(1'b0), g);
        exp_r[0] = model_gain(model_fir(1'b1), g);
        exp_l[1] = model_gain(sample_t'(hist_l[MID_TAP] >>> 1), g);
        exp_r[1] = model_gain(sample_t'(hist_r[MID_TAP] >>> 1), g);
    endtask

    // ------------------------------------------------------------
    // Bus drivers, all called on a falling edge
    // ------------------------------------------------------------
    task automatic apb_access(input logic [3:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        rdata   = prdata;
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic send_sample(input sample_t xl, input sample_t xr, input logic ghost);
        while (busy) begin
            @(negedge clk);
        end
        sample_in_valid = 1'b1;
        sample_in_l     = xl;
        sample_in_r     = xr;
        @(negedge clk);
        sample_in_valid = 1'b0;
        if (ghost) begin
            // DUT is in its push step now and must drop this one
            check_flag("busy", busy, 1'b1);
            sample_in_valid = 1'b1;
            sample_in_l     = ~xl;
            sample_in_r     = ~xr;
            @(negedge clk);
            sample_in_valid = 1'b0;
        end
    endtask

    task automatic wait_output();
        do begin
            @(negedge clk);
        end while (!sample_out_valid);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0] rdata;
        logic        err;
        sample_t     xl;
        sample_t     xr;
        int          total;

        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += int'(ROWS[r].count);
        end
        limit   = total * 2 * (NUM_TAPS + 12) + 3 * (NUM_ROWS + 6) + 200;
        sat_hi  = 0;
        sat_lo  = 0;
        lfsr    = 16'd58829;
        for (int k = 0; k < NUM_TAPS; k++) begin
            hist_l[k] = '0;
            hist_r[k] = '0;
        end

        clk             = 1'b0;
        reset           = 1'b1;
        sample_in_valid = 1'b0;
        sample_in_l     = '0;
        sample_in_r     = '0;
        paddr           = '0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        pwdata          = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_flag("busy", busy, 1'b0);
        check_flag("sample_out_valid", sample_out_valid, 1'b0);
        check_flag("pslverr", pslverr, 1'b0);
        check_flag("pready", pready, 1'b1);
        apb_access(REG_GAIN_ADDR, 1'b0, '0, rdata, err);
        check_word("prdata", rdata, 32'd16384);

        apb_access(REG_GAIN_ADDR, 1'b1, 32'h0000_1234, rdata, err);
        check_flag("pslverr", err, 1'b0);
        apb_access(REG_GAIN_ADDR, 1'b0, '0, rdata, err);
        check_word("prdata", rdata, 32'h0000_1234);
        apb_access(4'h4, 1'b1, 32'h0000_5555, rdata, err);
        check_flag("pslverr", err, 1'b1);
        apb_access(4'h4, 1'b0, '0, rdata, err);
        check_flag("pslverr", err, 1'b1);
        apb_access(REG_GAIN_ADDR, 1'b0, '0, rdata, err);
        check_word("prdata", rdata, 32'h0000_1234);

        for (int r = 0; r < NUM_ROWS; r++) begin
            apb_access(REG_GAIN_ADDR, 1'b1, 32'(ROWS[r].gain), rdata, err);
            check_flag("pslverr", err, 1'b0);
            for (int i = 0; i < int'(ROWS[r].count); i++) begin
                xl = make_input(ROWS[r].kind_l, i);
                xr = make_input(ROWS[r].kind_r, i);
                send_sample(xl, xr, ROWS[r].ghost);
                model_push(xl, xr, ROWS[r].gain);
                for (int n = 0; n < 2; n++) begin
                    wait_output();
                    check_sample("sample_out_l", sample_out_l, exp_l[n]);
                    check_sample("sample_out_r", sample_out_r, exp_r[n]);
                    // Impulse row reads the taps straight out
                    if (r == 0 && n == 0 && i < NUM_TAPS) begin
                        check_sample("sample_out_l", sample_out_l, COEFS[i]);
                    end
                    if (r == 0 && n == 1) begin
                        check_sample("sample_out_l", sample_out_l,
                                     (i == MID_TAP) ? sample_t'(32768) : sample_t'(0));
                    end
                    if (exp_l[n] == sample_t'(131071) || exp_r[n] == sample_t'(131071)) begin
                        sat_hi++;
                    end
                    if (exp_l[n] == sample_t'(-131072) || exp_r[n] == sample_t'(-131072)) begin
                        sat_lo++;
                    end
                end
            end
        end

        if (sat_hi == 0 || sat_lo == 0) begin
            fail_stop("Saturation limits were never reached by the stimulus");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
design/audio_pkg.sv
design/mac_if.sv
design/mac_unit.sv
design/mac_arbiter.sv
design/interpolator_2x.sv
design/gain_stage.sv
design/gain_regs.sv
design/audio_top.sv
dv/tb_audio_top.sv
